// ==== tb.f ====
source/idct_pkg.sv
source/ram_if.sv
source/block_ram.sv
source/dot_unit.sv
source/idct_ctrl.sv
source/idct_top.sv
verification/idct_chk.sv
verification/tb_idct.sv

// ==== verification/tb_idct.sv ====
module tb_idct;
	timeunit 1ns;
	timeprecision 1ps;
	import idct_pkg::*;

	localparam sram_addr_t IN_BASE = 18'd76800;
	localparam sram_addr_t OUT_BASE = 18'd200;
	localparam int CLK_PERIOD = 100;
	localparam int NUM_BLOCKS = 9;
	localparam int N_PIX = BLOCK_N * BLOCK_N;
	localparam longint TIMEOUT_NS = longint'(NUM_BLOCKS) * 800 * CLK_PERIOD;

	logic CLOCK_50;
	logic Resetn;
	logic start;
	sram_data_t SRAM_read_data;
	sram_addr_t SRAM_address;
	sram_data_t SRAM_write_data;
	logic we_n;
	logic done;

	sram_data_t sram [0:262143];
	sram_addr_t addr_q1;
	sram_addr_t addr_q2;
	logic [31:0] lfsr;
	coef_t blk [N_PIX];              // S' of the current block
	pixel_t exp_pix [N_PIX];
	int blocks_checked = 0;

	idct_top #(
		.IN_BASE(IN_BASE),
		.OUT_BASE(OUT_BASE)
	) UUT (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.start(start),
		.SRAM_read_data(SRAM_read_data),
		.SRAM_address(SRAM_address),
		.SRAM_write_data(SRAM_write_data),
		.we_n(we_n),
		.done(done)
	);

	bind idct_top idct_chk #(.OUT_BASE(OUT_BASE)) u_chk (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.start(start),
		.SRAM_address(SRAM_address),
		.we_n(we_n),
		.done(done)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	// SRAM model, address registered twice before data goes out
	always @(posedge CLOCK_50) begin
		addr_q1 <= SRAM_address;
		addr_q2 <= addr_q1;
		if (!we_n) sram[SRAM_address] <= SRAM_write_data;
	end

	always @(negedge CLOCK_50) SRAM_read_data <= sram[addr_q2];

	function automatic sram_data_t fill_word(input sram_addr_t a);
		return a[15:0] ^ {a[17:16], a[17:16], 12'h5a3};
	endfunction

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// T = S'C >>> 8, then S = C^T T >>> 16 clipped to a byte
	function automatic void ref_idct();
		longint t [N_PIX];
		longint sum;
		for (int i = 0; i < BLOCK_N; i++) begin
			for (int j = 0; j < BLOCK_N; j++) begin
				sum = 0;
				for (int k = 0; k < BLOCK_N; k++) begin
					sum += longint'(blk[i * BLOCK_N + k]) * longint'(COS_TABLE[k * BLOCK_N + j]);
				end
				t[i * BLOCK_N + j] = sum >>> ROW_SHIFT;
			end
		end
		for (int i = 0; i < BLOCK_N; i++) begin
			for (int j = 0; j < BLOCK_N; j++) begin
				sum = 0;
				for (int k = 0; k < BLOCK_N; k++) begin
					sum += longint'(COS_TABLE[k * BLOCK_N + i]) * t[k * BLOCK_N + j];
				end
				sum = sum >>> COL_SHIFT;
				if (sum < 0) exp_pix[i * BLOCK_N + j] = 8'd0;
				else if (sum > 255) exp_pix[i * BLOCK_N + j] = 8'd255;
				else exp_pix[i * BLOCK_N + j] = pixel_t'(sum);
			end
		end
	endfunction

	task automatic abort_run(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input sram_addr_t a, input sram_data_t got, input sram_data_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: word at %0d is %h, expected %h", $time, a, got, exp);
			abort_run("wrong output word");
		end
	endtask

	task automatic check_pixel(input int idx, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: pixel %0d is %0d, expected %0d", $time, idx, got, exp);
			abort_run("wrong output pixel");
		end
	endtask

	// compare the output area once per done
	always @(negedge CLOCK_50) begin : compare
		sram_addr_t a;
		sram_data_t w;
		if (Resetn && done) begin
			for (int n = 0; n < N_PIX / 2; n++) begin
				a = sram_addr_t'(OUT_BASE + n);
				w = sram[a];
				check_word(a, w, {exp_pix[2 * n], exp_pix[2 * n + 1]});    // even pixel in upper byte
			end
			blocks_checked++;
		end
	end

	always @(negedge CLOCK_50) begin
		if (UUT.u_chk.fail_count != 0) abort_run("an assertion in idct_chk failed");
	end

	initial begin
		#(TIMEOUT_NS);
		abort_run("watchdog timeout, done never arrived for every block");
	end

	task automatic run_block(input logic busy_start);
		int cycles;
		int target;
		target = blocks_checked + 1;
		for (int i = 0; i < N_PIX; i++) begin
			sram[IN_BASE + i] = sram_data_t'(blk[i]);
			if (i < N_PIX / 2) sram[OUT_BASE + i] = fill_word(sram_addr_t'(OUT_BASE + i));
		end
		ref_idct();
		@(negedge CLOCK_50);
		start = 1'b1;
		cycles = 0;
		while (blocks_checked != target) begin
			@(negedge CLOCK_50);
			start = busy_start && (cycles == 150);   // lands in the row pass
			cycles++;
		end
		start = 1'b0;
		if (busy_start) begin
			repeat (cycles + N_PIX) @(negedge CLOCK_50);    // room for a stray second done
		end
	endtask

	task automatic expect_flat();
		sram_data_t w;
		for (int n = 0; n < N_PIX / 2; n++) begin
			w = sram[OUT_BASE + n];
			check_pixel(2 * n, w[15:8], exp_pix[0]);
			check_pixel(2 * n + 1, w[7:0], exp_pix[0]);
		end
	endtask

	task automatic expect_clipping();
		int lows;
		int highs;
		lows = 0;
		highs = 0;
		for (int i = 0; i < N_PIX; i++) begin
			if (exp_pix[i] == 8'd0) lows++;
			if (exp_pix[i] == 8'd255) highs++;
		end
		if (lows == 0 || highs == 0) abort_run("clipping block does not reach both 0 and 255");
	endtask

	function automatic void fill_random();
		logic [31:0] v;
		logic signed [11:0] r;
		for (int i = 0; i < N_PIX; i++) begin
			v = take_bits(12);
			r = v[11:0];
			blk[i] = r;    // sign extended
		end
	endfunction

	initial begin
		Resetn = 1'b0;
		start = 1'b0;
		SRAM_read_data = '0;
		lfsr = 32'he10a;
		for (int a = 0; a < 262144; a++) begin
			sram[a] = fill_word(sram_addr_t'(a));
		end
		repeat (3) @(negedge CLOCK_50);
		Resetn = 1'b1;
		blk = '{default: '0};
		run_block(1'b0);
		blk[0] = 16'sd700;                 // DC only
		run_block(1'b0);
		expect_flat();
		blk[0] = 16'sd1800;
		run_block(1'b0);
		expect_flat();
		for (int b = 0; b < 4; b++) begin
			fill_random();
			run_block(b == 1);
		end
		blk = '{default: '0};
		blk[0] = 16'sd2047;
		blk[1] = 16'sd2047;
		run_block(1'b0);
		expect_clipping();
		for (int i = 0; i < N_PIX; i++) begin
			blk[i] = (take_bits(1) != 0) ? -16'sd2047 : 16'sd2047;
		end
		run_block(1'b0);
		if (blocks_checked == NUM_BLOCKS && UUT.u_chk.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run("not every block was checked or an assertion failed");
		end
	end

endmodule

// ==== verification/idct_chk.sv ====
module idct_chk #(
	parameter idct_pkg::sram_addr_t OUT_BASE = 18'd0
) (
	input logic CLOCK_50,
	input logic Resetn,
	input logic start,
	input idct_pkg::sram_addr_t SRAM_address,
	input logic we_n,
	input logic done
);
	timeunit 1ns;
	timeprecision 1ps;
	import idct_pkg::*;

	int unsigned fail_count = 0;
	logic armed;    // block started, done not yet seen

	always @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			armed <= 1'b0;
		end else if (start && !armed) begin
			armed <= 1'b1;
		end else if (done) begin
			armed <= 1'b0;
		end
	end

	reset_idle: assert property (@(posedge CLOCK_50) !Resetn |=> (we_n && !done))
		else begin
			$error("we_n or done active right after reset");
			fail_count++;
		end

	done_pulse: assert property (@(posedge CLOCK_50) disable iff (!Resetn) done |=> !done)
		else begin
			$error("done held for more than one cycle");
			fail_count++;
		end

	// offset from OUT_BASE wraps like the 18-bit bus
	write_range: assert property (@(posedge CLOCK_50) disable iff (!Resetn)
		!we_n |-> (sram_addr_t'(SRAM_address - OUT_BASE) < 18'd32))
		else begin
			$error("SRAM write outside the output area");
			fail_count++;
		end

	single_done: assert property (@(posedge CLOCK_50) disable iff (!Resetn) done |-> armed)
		else begin
			$error("done without a matching start");
			fail_count++;
		end

endmodule

// ==== source/idct_top.sv ====
module idct_top #(
	parameter idct_pkg::sram_addr_t IN_BASE = 18'd76800,
	parameter idct_pkg::sram_addr_t OUT_BASE = 18'd0
) (
	input logic CLOCK_50,
	input logic Resetn,
	input logic start,
	input idct_pkg::sram_data_t SRAM_read_data,
	output idct_pkg::sram_addr_t SRAM_address,
	output idct_pkg::sram_data_t SRAM_write_data,
	output logic we_n,
	output logic done
);
	import idct_pkg::*;

	pass_t pass;
	logic step;
	logic first;
	logic [1:0] pair;
	logic [2:0] col;
	acc_t op_a;
	acc_t op_b;
	acc_t result;
	logic result_valid;

	ram_if #(.word_t(coef_t)) sp_wr ();    // S' buffer ports
	ram_if #(.word_t(coef_t)) sp_rd ();
	ram_if #(.word_t(acc_t)) t_wr ();      // T buffer ports
	ram_if #(.word_t(acc_t)) t_rd ();

	idct_ctrl #(
		.IN_BASE(IN_BASE),
		.OUT_BASE(OUT_BASE)
	) u_ctrl (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.start(start),
		.SRAM_read_data(SRAM_read_data),
		.SRAM_address(SRAM_address),
		.SRAM_write_data(SRAM_write_data),
		.we_n(we_n),
		.done(done),
		.sp_wr(sp_wr.client),
		.sp_rd(sp_rd.client),
		.t_wr(t_wr.client),
		.t_rd(t_rd.client),
		.pass(pass),
		.step(step),
		.first(first),
		.pair(pair),
		.col(col),
		.op_a(op_a),
		.op_b(op_b),
		.result(result),
		.result_valid(result_valid)
	);

	block_ram #(.word_t(coef_t)) u_sp_ram (
		.CLOCK_50(CLOCK_50),
		.wr_port(sp_wr.mem),
		.rd_port(sp_rd.mem)
	);

	block_ram #(.word_t(acc_t)) u_t_ram (
		.CLOCK_50(CLOCK_50),
		.wr_port(t_wr.mem),
		.rd_port(t_rd.mem)
	);

	dot_unit u_dot (
		.CLOCK_50(CLOCK_50),
		.Resetn(Resetn),
		.pass(pass),
		.step(step),
		.first(first),
		.pair(pair),
		.col(col),
		.op_a(op_a),
		.op_b(op_b),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

// ==== source/idct_ctrl.sv ====
module idct_ctrl #(
	parameter idct_pkg::sram_addr_t IN_BASE = 18'd76800,
	parameter idct_pkg::sram_addr_t OUT_BASE = 18'd0
) (
	input logic CLOCK_50,
	input logic Resetn,
	input logic start,
	input idct_pkg::sram_data_t SRAM_read_data,
	output idct_pkg::sram_addr_t SRAM_address,
	output idct_pkg::sram_data_t SRAM_write_data,
	output logic we_n,
	output logic done,
	ram_if.client sp_wr,
	ram_if.client sp_rd,
	ram_if.client t_wr,
	ram_if.client t_rd,
	output idct_pkg::pass_t pass,
	output logic step,
	output logic first,
	output logic [1:0] pair,
	output logic [2:0] col,
	output idct_pkg::acc_t op_a,
	output idct_pkg::acc_t op_b,
	input idct_pkg::acc_t result,
	input logic result_valid
);
	import idct_pkg::*;

	localparam int N_COEF = BLOCK_N * BLOCK_N;
	localparam int N_WORDS = N_COEF / 2;
	localparam buf_addr_t LAST_IDX = buf_addr_t'(N_COEF - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_ROW,
		S_COL,
		S_WRITE
	} state_t;

	state_t state;
	logic req_valid;              // fetch address on the bus
	buf_addr_t req_idx;
	logic tag1_valid;
	logic tag2_valid;
	buf_addr_t tag1_idx;
	buf_addr_t tag2_idx;          // index of the word now on SRAM_read_data
	logic issuing;
	buf_addr_t out_idx;
	logic [1:0] pair_idx;
	buf_addr_t res_idx;
	logic [5:0] wb_cnt;
	pixel_t even_pix;
	pixel_t pix;
	sram_data_t out_regs [N_WORDS];

	function automatic pixel_t clip(input acc_t v);
		if (v < 0) return 8'd0;
		if (v > 255) return 8'd255;
		return pixel_t'(v[7:0]);
	endfunction

	assign pix = clip(result);
	assign pass = (state == S_COL) ? COL_PASS : ROW_PASS;
	assign op_a = (state == S_COL) ? t_wr.rdata : acc_t'(sp_wr.rdata);
	assign op_b = (state == S_COL) ? t_rd.rdata : acc_t'(sp_rd.rdata);

	// even k on the first port of each buffer, odd k on the second
	always_comb begin
		sp_wr.addr = tag2_idx;
		sp_wr.wdata = coef_t'(SRAM_read_data);
		sp_wr.wren = tag2_valid;
		sp_rd.addr = {out_idx[5:3], pair_idx, 1'b1};
		sp_rd.wdata = '0;
		sp_rd.wren = 1'b0;
		t_wr.addr = res_idx;
		t_wr.wdata = result;
		t_wr.wren = result_valid && (state == S_ROW);
		t_rd.addr = {pair_idx, 1'b1, out_idx[2:0]};
		t_rd.wdata = '0;
		t_rd.wren = 1'b0;
		if (state == S_ROW) sp_wr.addr = {out_idx[5:3], pair_idx, 1'b0};
		if (state == S_COL) t_wr.addr = {pair_idx, 1'b0, out_idx[2:0]};
	end

	always_ff @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			req_valid <= 1'b0;
			req_idx <= '0;
			SRAM_address <= '0;
			we_n <= 1'b1;
			done <= 1'b0;
			issuing <= 1'b0;
			out_idx <= '0;
			pair_idx <= '0;
			res_idx <= '0;
			wb_cnt <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin                // busy starts never reach here
						SRAM_address <= IN_BASE;
						req_valid <= 1'b1;
						req_idx <= '0;
						state <= S_FETCH;
					end
				end
				S_FETCH: begin
					if (req_valid) begin
						if (req_idx == LAST_IDX) begin
							req_valid <= 1'b0;
						end else begin
							SRAM_address <= SRAM_address + sram_addr_t'(1);
							req_idx <= req_idx + 1'b1;
						end
					end
					if (tag2_valid && tag2_idx == LAST_IDX) begin
						issuing <= 1'b1;
						out_idx <= '0;
						pair_idx <= '0;
						res_idx <= '0;
						state <= S_ROW;
					end
				end
				S_ROW, S_COL: begin
					if (issuing) begin
						pair_idx <= pair_idx + 1'b1;
						if (pair_idx == 2'd3) begin
							out_idx <= out_idx + 1'b1;
							if (out_idx == LAST_IDX) issuing <= 1'b0;
						end
					end
					if (result_valid) begin
						res_idx <= res_idx + 1'b1;
						if (res_idx == LAST_IDX && state == S_ROW) begin
							issuing <= 1'b1;         // T complete, start columns
							out_idx <= '0;
							pair_idx <= '0;
							state <= S_COL;
						end else if (res_idx == LAST_IDX) begin
							wb_cnt <= '0;
							state <= S_WRITE;
						end
					end
				end
				S_WRITE: begin
					if (wb_cnt != 6'(N_WORDS)) begin
						we_n <= 1'b0;
						SRAM_address <= OUT_BASE + sram_addr_t'(wb_cnt);
						wb_cnt <= wb_cnt + 1'b1;
					end else begin
						we_n <= 1'b1;
						done <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// step stage lines up with buffer read data
	always_ff @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			step <= 1'b0;
			first <= 1'b0;
			pair <= '0;
			col <= '0;
			tag1_valid <= 1'b0;
			tag2_valid <= 1'b0;
		end else begin
			step <= issuing;
			first <= (pair_idx == 2'd0);
			pair <= pair_idx;
			col <= (state == S_COL) ? out_idx[5:3] : out_idx[2:0];
			tag1_valid <= req_valid;
			tag2_valid <= tag1_valid;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		tag1_idx <= req_idx;
		tag2_idx <= tag1_idx;
		if (state == S_COL && result_valid) begin
			if (!res_idx[0]) even_pix <= pix;    // upper byte waits for its partner
			else out_regs[res_idx[5:1]] <= {even_pix, pix};
		end
		if (state == S_WRITE) SRAM_write_data <= out_regs[wb_cnt[4:0]];
	end

endmodule

// ==== source/dot_unit.sv ====
module dot_unit (
	input logic CLOCK_50,
	input logic Resetn,
	input idct_pkg::pass_t pass,
	input logic step,
	input logic first,
	input logic [1:0] pair,
	input logic [2:0] col,
	input idct_pkg::acc_t op_a,
	input idct_pkg::acc_t op_b,
	output idct_pkg::acc_t result,
	output logic result_valid
);
	import idct_pkg::*;

	logic signed [11:0] coef_a;
	logic signed [11:0] coef_b;
	acc_t prod_a;
	acc_t prod_b;
	acc_t acc;
	logic p_valid;
	logic p_first;
	logic p_last;
	pass_t p_pass;
	pass_t sum_pass;

	// rows 2*pair and 2*pair+1 of C at column col
	// in the column pass C^T[col][k] is the same entry
	always_comb begin
		coef_a = COS_TABLE[(2 * pair) * BLOCK_N + col];
		coef_b = COS_TABLE[(2 * pair + 1) * BLOCK_N + col];
	end

	// product stage
	always_ff @(posedge CLOCK_50) begin
		prod_a <= op_a * coef_a;
		prod_b <= op_b * coef_b;
	end

	always_ff @(posedge CLOCK_50 or negedge Resetn) begin
		if (!Resetn) begin
			p_valid <= 1'b0;
			p_first <= 1'b0;
			p_last <= 1'b0;
			p_pass <= ROW_PASS;
			result_valid <= 1'b0;
		end else begin
			p_valid <= step;
			p_first <= first;
			p_last <= (pair == 2'd3);
			p_pass <= pass;
			result_valid <= p_valid && p_last;    // sum complete next cycle
		end
	end

	// accumulate stage, a first pair restarts the sum
	always_ff @(posedge CLOCK_50) begin
		if (p_valid) begin
			if (p_first) begin
				acc <= prod_a + prod_b;
				sum_pass <= p_pass;
			end else begin
				acc <= acc + prod_a + prod_b;
			end
		end
	end

	// scaling follows the pass the sum started in
	assign result = (sum_pass == COL_PASS) ? (acc >>> COL_SHIFT) : (acc >>> ROW_SHIFT);

endmodule

// ==== source/block_ram.sv ====
module block_ram #(
	parameter type word_t = logic [15:0]
) (
	input logic CLOCK_50,
	ram_if.mem wr_port,
	ram_if.mem rd_port
);

	word_t mem [0:63];

	// both ports may write and both read back registered
	always_ff @(posedge CLOCK_50) begin
		if (wr_port.wren) begin
			mem[wr_port.addr] <= wr_port.wdata;
		end
		if (rd_port.wren) begin
			mem[rd_port.addr] <= rd_port.wdata;
		end
		wr_port.rdata <= mem[wr_port.addr];    // old data on a write
		rd_port.rdata <= mem[rd_port.addr];
	end

endmodule

// ==== source/ram_if.sv ====
interface ram_if #(
	parameter type word_t = logic [15:0]
) ();
	import idct_pkg::*;

	buf_addr_t addr;
	word_t wdata;
	logic wren;
	word_t rdata;    // valid one clock after addr

	modport client (
		output addr,
		output wdata,
		output wren,
		input rdata
	);

	modport mem (
		input addr,
		input wdata,
		input wren,
		output rdata
	);

endinterface

// ==== source/idct_pkg.sv ====
package idct_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic signed [15:0] coef_t;     // S' coefficient
	typedef logic signed [31:0] acc_t;      // product sums and T values
	typedef logic [7:0] pixel_t;
	typedef logic [5:0] buf_addr_t;         // one 8x8 block

	typedef enum logic {
		ROW_PASS,
		COL_PASS
	} pass_t;

	localparam int BLOCK_N = 8;
	localparam int ROW_SHIFT = 8;
	localparam int COL_SHIFT = 16;

	// C[k][j], row k holds cosine frequency k
	localparam logic signed [11:0] COS_TABLE [0:63] = '{
		1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448,
		2008,  1702,  1137,   399,  -399, -1137, -1702, -2008,
		1892,   783,  -783, -1892, -1892,  -783,   783,  1892,
		1702,  -399, -2008, -1137,  1137,  2008,   399, -1702,
		1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448,
		1137, -2008,   399,  1702, -1702,  -399,  2008, -1137,
		 783, -1892,  1892,  -783,  -783,  1892, -1892,   783,
		 399, -1137,  1702, -2008,  2008, -1702,  1137,  -399
	};

endpackage
